/* flist.f */
hw/video_stream_pkg.sv
hw/frame_geom_pkg.sv
hw/pattern_gen.sv
hw/stream_fifo.sv
hw/insert_blank.sv
hw/video_blank_top.sv
testbench/tb_clkgen.sv
testbench/video_blank_assert.sv
testbench/tb_video_blank.sv

/* hw/frame_geom_pkg.sv */
// frame geometry and buffering constants
// counters wrap silently, so frames must fit the widths below
`default_nettype none

package frame_geom_pkg;

	// pixels per line counter
	localparam int X_WIDTH = 10;
	// lines per frame counter
	localparam int Y_WIDTH = 10;
	// number of blank lines after a frame
	localparam int BLANK_WIDTH = 8;
	// idle cycles between frames
	localparam int GAP_WIDTH = 16;

	// log2 of FIFO depth, 8 entries
	localparam int FIFO_PTR_WIDTH = 3;

	// line count in use until the first frame has been measured
	localparam logic [Y_WIDTH-1:0] INIT_Y_NUM = '0;

endpackage

`default_nettype wire

/* hw/insert_blank.sv */
// fills idle time after a frame with blank lines of zero pixels
// geometry is measured from the stream, so the first frame gets no blanking
// blanking stops at a line boundary as soon as input is waiting
// single output register stage, advances when empty or out_ready is high
`default_nettype none

module insert_blank (
	input  logic                                   clk,
	input  logic                                   reset,
	input  logic [frame_geom_pkg::BLANK_WIDTH-1:0] param_blank_num,
	input  video_stream_pkg::axis_beat_t           in_beat,
	input  logic                                   in_valid,
	output logic                                   in_ready,
	output video_stream_pkg::axis_beat_t           out_beat,
	output logic                                   out_valid,
	input  logic                                   out_ready,
	output logic [frame_geom_pkg::X_WIDTH-1:0]     monitor_x_num,
	output logic [frame_geom_pkg::Y_WIDTH-1:0]     monitor_y_num
);

	// measured geometry
	logic [frame_geom_pkg::X_WIDTH-1:0]     x_cnt;
	logic [frame_geom_pkg::X_WIDTH-1:0]     x_num;
	logic [frame_geom_pkg::Y_WIDTH-1:0]     y_cnt;
	logic [frame_geom_pkg::Y_WIDTH-1:0]     y_num;
	logic [frame_geom_pkg::Y_WIDTH-1:0]     line_idx;

	// blank generation
	logic [frame_geom_pkg::X_WIDTH-1:0]     x_blank;
	logic [frame_geom_pkg::BLANK_WIDTH-1:0] y_blank;
	logic                                   blank_active;
	logic                                   frame_last;

	logic                                   out_adv;
	logic                                   in_xfer;
	logic                                   blank_start;
	logic                                   blank_cont;
	logic                                   blank_last;
	video_stream_pkg::axis_beat_t           blank_beat;

	assign out_adv  = !out_valid || out_ready;
	assign in_ready = out_adv && (!blank_active || frame_last);
	assign in_xfer  = in_valid && in_ready;

	// line index of the incoming beat, start of frame restarts at 0
	assign line_idx = in_beat.user ? '0 : y_cnt;

	// new blank line only at a line boundary with nothing waiting
	assign blank_start = frame_last && !in_valid && (y_blank != param_blank_num);
	assign blank_cont  = blank_active && !frame_last;

	assign blank_last = blank_start ? (x_num == '0) : (x_blank + 1'b1 == x_num);

	always_comb begin
		blank_beat.data = video_stream_pkg::BLANK_PIXEL;
		blank_beat.last = blank_last;
		blank_beat.user = 1'b0;
	end

	// ------------------------------
	// geometry measurement
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			x_cnt <= '0;
			x_num <= '0;
			y_cnt <= '0;
			y_num <= frame_geom_pkg::INIT_Y_NUM;
		end else if (in_xfer) begin
			// line count of the previous frame, kept only once measured
			if (in_beat.user && (y_cnt != '0)) begin
				y_num <= y_cnt;
			end
			if (in_beat.last) begin
				x_num <= x_cnt;
				x_cnt <= '0;
				y_cnt <= line_idx + 1'b1;
			end else begin
				x_cnt <= x_cnt + 1'b1;
				y_cnt <= line_idx;
			end
		end
	end

	// ------------------------------
	// output control
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			x_blank      <= '0;
			y_blank      <= '0;
			blank_active <= 1'b0;
			frame_last   <= 1'b0;
			out_valid    <= 1'b0;
		end else if (out_adv) begin
			if (blank_start) begin
				y_blank      <= y_blank + 1'b1;
				x_blank      <= '0;
				blank_active <= 1'b1;
				frame_last   <= blank_last;
				out_valid    <= 1'b1;
			end else if (blank_cont) begin
				x_blank    <= x_blank + 1'b1;
				frame_last <= blank_last;
				out_valid  <= 1'b1;
			end else begin
				// pass-through, blanking over or never started
				blank_active <= 1'b0;
				y_blank      <= '0;
				out_valid    <= in_valid;
				frame_last   <= in_valid && in_beat.last && (line_idx + 1'b1 == y_num);
			end
		end
	end

	// output payload
	always_ff @(posedge clk) begin
		if (out_adv) begin
			if (blank_start || blank_cont) begin
				out_beat <= blank_beat;
			end else begin
				out_beat <= in_beat;
			end
		end
	end

	assign monitor_x_num = x_num;
	assign monitor_y_num = y_num;

endmodule

`default_nettype wire

/* hw/pattern_gen.sv */
// test pattern source, pixel = x + 3*y + 16*frame (low 8 bits)
// geometry inputs must be nonzero and stay stable while enable is high
// dropping enable lets the current frame finish before stopping
`default_nettype none

module pattern_gen (
	input  logic                                   clk,
	input  logic                                   reset,
	input  logic                                   enable,
	input  logic [frame_geom_pkg::X_WIDTH-1:0]     param_x_num,
	input  logic [frame_geom_pkg::Y_WIDTH-1:0]     param_y_num,
	input  logic [frame_geom_pkg::GAP_WIDTH-1:0]   param_gap,
	output video_stream_pkg::axis_beat_t           out_beat,
	output logic                                   out_valid,
	input  logic                                   out_ready
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_RUN,
		ST_GAP
	} state_t;

	state_t state;

	logic [frame_geom_pkg::X_WIDTH-1:0]   x_cnt;
	logic [frame_geom_pkg::Y_WIDTH-1:0]   y_cnt;
	logic [3:0]                           frame_cnt;
	logic [frame_geom_pkg::GAP_WIDTH-1:0] gap_cnt;

	logic xfer;
	logic line_end;
	logic frame_end;

	assign xfer      = out_valid && out_ready;
	assign line_end  = (x_cnt == param_x_num - 1'b1);
	assign frame_end = line_end && (y_cnt == param_y_num - 1'b1);

	// ------------------------------
	// beat content from counters
	// ------------------------------
	assign out_valid = (state == ST_RUN);

	always_comb begin
		// only frame mod 16 matters for 16*f in 8 bits
		out_beat.data = x_cnt[video_stream_pkg::DATA_WIDTH-1:0]
			+ {y_cnt[video_stream_pkg::DATA_WIDTH-2:0], 1'b0}
			+ y_cnt[video_stream_pkg::DATA_WIDTH-1:0]
			+ {frame_cnt, 4'h0};
		out_beat.last = line_end;
		out_beat.user = (x_cnt == '0) && (y_cnt == '0);
	end

	// ------------------------------
	// frame sequencing
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= ST_IDLE;
			x_cnt     <= '0;
			y_cnt     <= '0;
			frame_cnt <= '0;
			gap_cnt   <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (enable) begin
						state <= ST_RUN;
						x_cnt <= '0;
						y_cnt <= '0;
					end
				end
				ST_RUN: begin
					// back-pressure just holds the counters
					if (xfer) begin
						if (!line_end) begin
							x_cnt <= x_cnt + 1'b1;
						end else begin
							x_cnt <= '0;
							if (!frame_end) begin
								y_cnt <= y_cnt + 1'b1;
							end else begin
								y_cnt     <= '0;
								frame_cnt <= frame_cnt + 1'b1;
								gap_cnt   <= frame_geom_pkg::GAP_WIDTH'(1);
								if (!enable) begin
									state <= ST_IDLE;
								end else if (param_gap != '0) begin
									state <= ST_GAP;
								end
							end
						end
					end
				end
				ST_GAP: begin
					// valid stays low for param_gap cycles
					if (!enable) begin
						state <= ST_IDLE;
					end else if (gap_cnt == param_gap) begin
						state <= ST_RUN;
					end else begin
						gap_cnt <= gap_cnt + 1'b1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/stream_fifo.sv */
// synchronous FIFO with valid/ready on both sides
// depth is 2**FIFO_PTR_WIDTH, payload is any packed type
// data is read straight from the array, so out_data is valid with out_valid
// when full, in_ready follows out_ready to allow a read and write together
`default_nettype none

module stream_fifo #(
	parameter type payload_t = video_stream_pkg::axis_beat_t
) (
	input  logic     clk,
	input  logic     reset,
	input  payload_t in_data,
	input  logic     in_valid,
	output logic     in_ready,
	output payload_t out_data,
	output logic     out_valid,
	input  logic     out_ready
);

	payload_t mem [0:(1 << frame_geom_pkg::FIFO_PTR_WIDTH)-1];

	logic [frame_geom_pkg::FIFO_PTR_WIDTH-1:0] wr_ptr;
	logic [frame_geom_pkg::FIFO_PTR_WIDTH-1:0] rd_ptr;
	// one extra bit, msb set means full
	logic [frame_geom_pkg::FIFO_PTR_WIDTH:0]   count;

	logic full;
	logic wr_en;
	logic rd_en;

	assign full      = count[frame_geom_pkg::FIFO_PTR_WIDTH];
	assign out_valid = (count != '0);
	assign in_ready  = !full || out_ready;

	assign wr_en = in_valid && in_ready;
	assign rd_en = out_valid && out_ready;

	assign out_data = mem[rd_ptr];

	// ------------------------------
	// storage
	// ------------------------------
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= in_data;
		end
	end

	// ------------------------------
	// pointers and occupancy
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// pointers wrap on their own width
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/video_blank_top.sv */
// pattern generator -> FIFO -> blank inserter
// settings are plain levels, held stable while enable is high
// latency to m_beat is two cycles or more, depending on FIFO fill
`default_nettype none

module video_blank_top (
	input  logic                                   clk,
	input  logic                                   reset,
	input  logic                                   enable,
	input  logic [frame_geom_pkg::X_WIDTH-1:0]     param_x_num,
	input  logic [frame_geom_pkg::Y_WIDTH-1:0]     param_y_num,
	input  logic [frame_geom_pkg::GAP_WIDTH-1:0]   param_gap,
	input  logic [frame_geom_pkg::BLANK_WIDTH-1:0] param_blank_num,
	output video_stream_pkg::axis_beat_t           m_beat,
	output logic                                   m_valid,
	input  logic                                   m_ready,
	output logic [frame_geom_pkg::X_WIDTH-1:0]     monitor_x_num,
	output logic [frame_geom_pkg::Y_WIDTH-1:0]     monitor_y_num
);

	// generator to FIFO
	video_stream_pkg::axis_beat_t gen_beat;
	logic                         gen_valid;
	logic                         gen_ready;

	// FIFO to inserter
	video_stream_pkg::axis_beat_t fifo_beat;
	logic                         fifo_valid;
	logic                         fifo_ready;

	pattern_gen i_gen (
		.clk         (clk),
		.reset       (reset),
		.enable      (enable),
		.param_x_num (param_x_num),
		.param_y_num (param_y_num),
		.param_gap   (param_gap),
		.out_beat    (gen_beat),
		.out_valid   (gen_valid),
		.out_ready   (gen_ready)
	);

	stream_fifo #(
		.payload_t (video_stream_pkg::axis_beat_t)
	) i_fifo (
		.clk       (clk),
		.reset     (reset),
		.in_data   (gen_beat),
		.in_valid  (gen_valid),
		.in_ready  (gen_ready),
		.out_data  (fifo_beat),
		.out_valid (fifo_valid),
		.out_ready (fifo_ready)
	);

	insert_blank i_ins (
		.clk             (clk),
		.reset           (reset),
		.param_blank_num (param_blank_num),
		.in_beat         (fifo_beat),
		.in_valid        (fifo_valid),
		.in_ready        (fifo_ready),
		.out_beat        (m_beat),
		.out_valid       (m_valid),
		.out_ready       (m_ready),
		.monitor_x_num   (monitor_x_num),
		.monitor_y_num   (monitor_y_num)
	);

endmodule

`default_nettype wire

/* hw/video_stream_pkg.sv */
// stream types shared by generator, FIFO and inserter
// one pixel per beat, only start of frame and end of line as side channels
`default_nettype none

package video_stream_pkg;

	// pixel width in bits
	localparam int DATA_WIDTH = 8;

	typedef logic [DATA_WIDTH-1:0] pixel_t;

	// one beat of the pixel stream, 10 bits wide
	typedef struct packed {
		pixel_t data;
		// end of line
		logic   last;
		// start of frame, first pixel of line 0
		logic   user;
	} axis_beat_t;

	// data of the pixels filled in during blanking
	localparam pixel_t BLANK_PIXEL = '0;

endpackage

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log for the pass line.

cd "$(dirname "$0")" || exit 1

build_dir=build
log_file=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tb_video_blank -Mdir "$build_dir" -o tb_video_blank -f flist.f; then
	echo "verilator build failed"
	exit 1
fi

"./$build_dir/tb_video_blank" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if [ "$sim_status" -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "=== PASS ===" "$log_file"; then
	exit 0
else
	echo "pass line not found in $log_file"
	exit 1
fi

/* testbench/tb_clkgen.sv */
// free running clock and synchronous reset for the testbench
// reset is high for RESET_CYCLES rising edges at start and after each restart pulse
`default_nettype none

module tb_clkgen #(
	parameter int PERIOD_NS    = 20,
	parameter int RESET_CYCLES = 3
) (
	input  logic restart,
	output logic clk,
	output logic reset
);
	timeunit 1ns;
	timeprecision 100ps;

	logic rst_q   = 1'b1;
	int   rst_cnt = 0;

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		if (restart) begin
			rst_q   <= 1'b1;
			rst_cnt <= 0;
		end else if (rst_q) begin
			if (rst_cnt == RESET_CYCLES - 1) begin
				rst_q <= 1'b0;
			end
			rst_cnt <= rst_cnt + 1;
		end
	end

	assign reset = rst_q;

endmodule

`default_nettype wire

/* testbench/tb_video_blank.sv */
// testbench for the generator, FIFO and blank inserter chain
// DUT inputs change on the falling edge
// outputs are collected on the rising edge
// the DUT is reset before each stream test, so frame indices restart at 0
`default_nettype none

module tb_video_blank;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT_CYCLES = 5000;
	localparam int QUIET_CYCLES   = 100;
	localparam int LONG_GAP       = 200;
	// idle time after the last frame never ends
	localparam int END_GAP        = 1000000;

	logic                                   clk;
	logic                                   reset;
	logic                                   restart;
	logic                                   enable;
	logic [frame_geom_pkg::X_WIDTH-1:0]     param_x_num;
	logic [frame_geom_pkg::Y_WIDTH-1:0]     param_y_num;
	logic [frame_geom_pkg::GAP_WIDTH-1:0]   param_gap;
	logic [frame_geom_pkg::BLANK_WIDTH-1:0] param_blank_num;
	video_stream_pkg::axis_beat_t           m_beat;
	logic                                   m_valid;
	logic                                   m_ready = 1'b1;
	logic [frame_geom_pkg::X_WIDTH-1:0]     monitor_x_num;
	logic [frame_geom_pkg::Y_WIDTH-1:0]     monitor_y_num;

	video_stream_pkg::axis_beat_t out_q[$];
	video_stream_pkg::axis_beat_t exp_q[$];

	integer seed = 95998;
	bit     ready_random;
	bit     timed_out;
	int     user_seen;
	int     err_cnt;
	int     pass_cnt;
	int     fail_cnt;

	tb_clkgen #(
		.PERIOD_NS    (20),
		.RESET_CYCLES (3)
	) i_clkgen (
		.restart (restart),
		.clk     (clk),
		.reset   (reset)
	);

	video_blank_top i_dut (
		.clk             (clk),
		.reset           (reset),
		.enable          (enable),
		.param_x_num     (param_x_num),
		.param_y_num     (param_y_num),
		.param_gap       (param_gap),
		.param_blank_num (param_blank_num),
		.m_beat          (m_beat),
		.m_valid         (m_valid),
		.m_ready         (m_ready),
		.monitor_x_num   (monitor_x_num),
		.monitor_y_num   (monitor_y_num)
	);

	// ------------------------------
	// back-pressure and output capture
	// ------------------------------
	always @(negedge clk) begin
		if (ready_random) begin
			m_ready = 1'($random(seed));
		end else begin
			m_ready = 1'b1;
		end
	end

	always @(posedge clk) begin
		if (!reset && m_valid && m_ready) begin
			out_q.push_back(m_beat);
			if (m_beat.user) begin
				user_seen++;
			end
		end
	end

	// ------------------------------
	// reference model
	// ------------------------------
	// pushes frame f and its known blank lines onto exp_q
	// and returns how many blank lines may follow when timing leaves the count open
	function automatic int expect_frame(input int w, input int h, input int gap,
		input int blank, input int f);
		video_stream_pkg::axis_beat_t b;
		int x;
		int y;
		int fixed_lines;
		int loose;
		fixed_lines = 0;
		loose = 0;
		for (y = 0; y < h; y++) begin
			for (x = 0; x < w; x++) begin
				b.data = video_stream_pkg::pixel_t'(x + 3 * y + 16 * f);
				b.last = (x == w - 1);
				b.user = (x == 0) && (y == 0);
				exp_q.push_back(b);
			end
		end
		// frame 0 ends before any line count is measured
		if (f != 0) begin
			if (gap >= (blank + 1) * (w + 4) + 16) begin
				fixed_lines = blank;
			end else begin
				loose = blank;
			end
		end
		for (y = 0; y < fixed_lines; y++) begin
			for (x = 0; x < w; x++) begin
				b.data = 8'h00;
				b.last = (x == w - 1);
				b.user = 1'b0;
				exp_q.push_back(b);
			end
		end
		return loose;
	endfunction

	// ------------------------------
	// waits and comparison
	// ------------------------------
	task automatic wait_output(output bit ok);
		int waited;
		waited = 0;
		while (out_q.size() == 0 && !timed_out && waited < TIMEOUT_CYCLES) begin
			@(negedge clk);
			waited++;
		end
		ok = (out_q.size() != 0);
		if (!ok && !timed_out) begin
			$display("timeout waiting for an output beat at time %0t", $time);
			timed_out = 1'b1;
			err_cnt++;
		end
	endtask

	task automatic next_output(output video_stream_pkg::axis_beat_t b, output bit ok);
		wait_output(ok);
		if (ok) begin
			b = out_q.pop_front();
		end else begin
			b = '0;
		end
	endtask

	task automatic compare_beat(input video_stream_pkg::axis_beat_t got,
		input video_stream_pkg::axis_beat_t want, input string what);
		string got_s;
		string want_s;
		got_s  = $sformatf("data %02h last %0b user %0b", got.data, got.last, got.user);
		want_s = $sformatf("data %02h last %0b user %0b", want.data, want.last, want.user);
		assert (got == want) else begin
			$display("MISMATCH at time %0t: %s got %s, expected %s",
				$time, what, got_s, want_s);
			err_cnt++;
		end
	endtask

	task automatic check_frames(input int w, input int h, input int gap, input int blank,
		input int frames);
		video_stream_pkg::axis_beat_t got;
		video_stream_pkg::axis_beat_t want;
		video_stream_pkg::axis_beat_t zero_beat;
		int f;
		int i;
		int x;
		int loose;
		int lines;
		bit ok;
		bit done;
		zero_beat = '0;
		for (f = 0; f < frames; f++) begin
			exp_q.delete();
			loose = expect_frame(w, h, (f == frames - 1) ? END_GAP : gap, blank, f);
			i = 0;
			while (exp_q.size() != 0) begin
				want = exp_q.pop_front();
				next_output(got, ok);
				if (ok) begin
					compare_beat(got, want, $sformatf("frame %0d beat %0d", f, i));
				end
				i++;
			end
			// blank lines of open count up to the next start of frame
			lines = 0;
			done = (loose == 0);
			while (!done) begin
				wait_output(ok);
				if (!ok) begin
					done = 1'b1;
				end else if (out_q[0].user) begin
					done = 1'b1;
				end else begin
					assert (lines < loose) else begin
						$display("MISMATCH at time %0t: over %0d blank lines after frame %0d",
							$time, loose, f);
						err_cnt++;
					end
					for (x = 0; x < w; x++) begin
						zero_beat.last = (x == w - 1);
						next_output(got, ok);
						if (ok) begin
							compare_beat(got, zero_beat,
								$sformatf("blank line %0d after frame %0d pixel %0d",
								lines, f, x));
						end
					end
					lines++;
					// stop once more lines came than allowed
					done = (lines > loose);
				end
			end
		end
	endtask

	// drops enable once the last wanted frame has started at the output
	task automatic stop_after_frames(input int frames);
		int waited;
		waited = 0;
		while (user_seen < frames && !timed_out && waited < TIMEOUT_CYCLES) begin
			@(negedge clk);
			waited++;
		end
		if (user_seen < frames && !timed_out) begin
			$display("timeout waiting for frame %0d to start", frames - 1);
			timed_out = 1'b1;
			err_cnt++;
		end
		enable = 1'b0;
	endtask

	task automatic check_quiet(input int num);
		int i;
		for (i = 0; i < QUIET_CYCLES; i++) begin
			@(negedge clk);
		end
		assert (out_q.size() == 0) else begin
			$display("MISMATCH at time %0t: %0d unexpected beats after the last frame of test %0d",
				$time, out_q.size(), num);
			err_cnt++;
		end
	endtask

	task automatic apply_reset();
		int waited;
		enable = 1'b0;
		@(negedge clk);
		// the power-on reset is still running on the first call
		if (!reset) begin
			restart = 1'b1;
			@(negedge clk);
			restart = 1'b0;
		end
		waited = 0;
		while (reset && waited < TIMEOUT_CYCLES) begin
			@(negedge clk);
			waited++;
		end
		if (reset) begin
			$display("timeout waiting for reset to be released");
			timed_out = 1'b1;
			err_cnt++;
		end
		out_q.delete();
		user_seen = 0;
	endtask

	task automatic report_test(input int num, input string name, input int errs_before);
		if (err_cnt == errs_before) begin
			pass_cnt++;
			$display("test %0d %s: ok", num, name);
		end else begin
			fail_cnt++;
			$display("test %0d %s: failed with %0d errors", num, name, err_cnt - errs_before);
		end
	endtask

	task automatic run_stream_test(input int num, input string name, input int w, input int h,
		input int gap, input int blank, input int frames, input bit random_ready);
		int errs_before;
		errs_before = err_cnt;
		apply_reset();
		param_x_num     = frame_geom_pkg::X_WIDTH'(w);
		param_y_num     = frame_geom_pkg::Y_WIDTH'(h);
		param_gap       = frame_geom_pkg::GAP_WIDTH'(gap);
		param_blank_num = frame_geom_pkg::BLANK_WIDTH'(blank);
		ready_random    = random_ready;
		enable          = 1'b1;
		fork
			stop_after_frames(frames);
			check_frames(w, h, gap, blank, frames);
		join
		check_quiet(num);
		report_test(num, name, errs_before);
	endtask

	task automatic check_monitors(input int num, input int w, input int h);
		int errs_before;
		errs_before = err_cnt;
		assert (monitor_x_num == frame_geom_pkg::X_WIDTH'(w - 1)) else begin
			$display("MISMATCH at time %0t: monitor_x_num is %0d, expected %0d",
				$time, monitor_x_num, w - 1);
			err_cnt++;
		end
		assert (monitor_y_num == frame_geom_pkg::Y_WIDTH'(h)) else begin
			$display("MISMATCH at time %0t: monitor_y_num is %0d, expected %0d",
				$time, monitor_y_num, h);
			err_cnt++;
		end
		report_test(num, "geometry monitors", errs_before);
	endtask

	// ------------------------------
	// test sequence
	// ------------------------------
	initial begin
		restart         = 1'b0;
		enable          = 1'b0;
		param_x_num     = '0;
		param_y_num     = '0;
		param_gap       = '0;
		param_blank_num = '0;
		ready_random    = 1'b0;
		timed_out       = 1'b0;
		user_seen       = 0;
		err_cnt         = 0;
		pass_cnt        = 0;
		fail_cnt        = 0;

		run_stream_test(1, "pixel content", 8, 4, LONG_GAP, 0, 3, 1'b0);
		run_stream_test(2, "blank insertion", 6, 3, LONG_GAP, 2, 3, 1'b0);
		// geometry stays as measured in test 2 until the next reset
		check_monitors(3, 6, 3);
		run_stream_test(4, "back-pressure", 6, 3, LONG_GAP, 2, 3, 1'b1);
		run_stream_test(5, "early stop", 5, 4, 0, 5, 3, 1'b0);

		$display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && err_cnt == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/video_blank_assert.sv */
// handshake and framing checks on the top level, attached with bind
// internal valids of generator and FIFO are checked for reset only
`default_nettype none

module video_blank_assert (
	input logic                         clk,
	input logic                         reset,
	input video_stream_pkg::axis_beat_t m_beat,
	input logic                         m_valid,
	input logic                         m_ready,
	input logic                         gen_valid,
	input logic                         fifo_valid
);
	timeunit 1ns;
	timeprecision 100ps;

	// high while the next output beat must start a line
	logic after_last;

	always_ff @(posedge clk) begin
		if (reset) begin
			after_last <= 1'b1;
		end else if (m_valid && m_ready) begin
			after_last <= m_beat.last;
		end
	end

	// every valid cleared by a reset edge
	reset_clears_valid: assert property (@(posedge clk)
		reset |=> !(m_valid || gen_valid || fifo_valid))
		else $error("valid high after a reset edge");

	output_stable: assert property (@(posedge clk) disable iff (reset)
		(m_valid && !m_ready) |=> (m_valid && $stable(m_beat)))
		else $error("output beat changed while stalled");

	sof_after_eol: assert property (@(posedge clk) disable iff (reset)
		(m_valid && m_beat.user) |-> after_last)
		else $error("start of frame not preceded by end of line");

endmodule

bind video_blank_top video_blank_assert i_assert (
	.clk        (clk),
	.reset      (reset),
	.m_beat     (m_beat),
	.m_valid    (m_valid),
	.m_ready    (m_ready),
	.gen_valid  (gen_valid),
	.fifo_valid (fifo_valid)
);

`default_nettype wire
